// File: aluUnit.f
rtl/aluPkg.sv
rtl/aluDecoder.sv
rtl/aluRegFile.sv
rtl/aluDatapath.sv
rtl/aluUnit.sv
sim/aluClockGen.sv
sim/aluTb.sv

// File: rtl/aluDatapath.sv
module aluDatapath (
  input  logic              DSPCLK,
  input  logic              T_RST,
  input  aluPkg::dspWord    xOperand,
  input  aluPkg::dspWord    yOperand,
  input  logic              zeroX,
  input  logic              invX,
  input  logic              zeroY,
  input  logic              invY,
  input  logic              carryIn,
  input  logic              logicK,
  input  logic              logicL,
  input  logic              addSel,
  input  logic              absSel,
  input  logic              updFlags,
  output aluPkg::dspWord    aluResult,
  output aluPkg::statusWord astat,
  output logic              acFlag,
  output logic              xSign
);
  import aluPkg::*;

  dspWord      xGated;
  dspWord      yGated;
  dspWord      logicOut;
  logic [16:0] sumFull;
  logic        overflow;
  statusWord   statusNext;

  // Operand conditioning ahead of the adder and the logic unit
  assign xGated = (zeroX ? '0 : xOperand) ^ {16{invX}};
  assign yGated = (zeroY ? '0 : yOperand) ^ {16{invY}};

  assign sumFull  = {1'b0, xGated} + {1'b0, yGated} + 17'(carryIn);
  assign overflow = (xGated[15] == yGated[15]) && (sumFull[15] != xGated[15]);  // Signed

  always_comb
  begin
    case ({logicK, logicL})
      2'b00:   logicOut = xGated & yGated;
      2'b01:   logicOut = xGated | yGated;
      default: logicOut = xGated ^ yGated;
    endcase
  end

  assign aluResult = addSel ? sumFull[15:0] : logicOut;

  always_comb
  begin
    statusNext        = astat;
    statusNext[aZBit] = (aluResult == '0);
    statusNext[aNBit] = aluResult[15];
    statusNext[aVBit] = addSel && overflow;  // Logic operations clear AV and AC
    statusNext[aCBit] = addSel && sumFull[16];
    if (absSel)
      statusNext[aSBit] = xOperand[15];  // Sign of the X input to ABS
  end

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
      astat <= '0;
    else if (updFlags)
      astat <= statusNext;
  end

  assign acFlag = astat[aCBit];
  assign xSign  = xOperand[15];

endmodule

// File: rtl/aluDecoder.sv
module aluDecoder (
  input  logic              DSPCLK,
  input  logic              T_RST,
  input  logic              instValid,
  input  aluPkg::aluFunc    func,
  input  logic              absOp,
  input  aluPkg::xSel       xop,
  input  aluPkg::ySel       yop,
  input  aluPkg::constField yy,
  input  aluPkg::constField cc,
  input  aluPkg::constField bo,
  input  logic              toAf,
  input  logic              moveValid,
  input  aluPkg::moveTarget moveReg,
  input  aluPkg::dspWord    moveData,
  input  logic              shadow,
  input  logic              acFlag,
  input  logic              xSign,
  output logic              updAX0r,
  output logic              updAX0s,
  output logic              updAX1r,
  output logic              updAX1s,
  output logic              updAY0r,
  output logic              updAY0s,
  output logic              updAY1r,
  output logic              updAY1s,
  output logic              updARr,
  output logic              updARs,
  output logic              updAFr,
  output logic              updAFs,
  output logic [1:0]        resultIsMove,
  output aluPkg::dspWord    moveDataE,
  output aluPkg::xSel       xopE,
  output aluPkg::ySel       yopE,
  output logic              shadowE,
  output aluPkg::dspWord    constE,
  output logic              zeroX,
  output logic              invX,
  output logic              zeroY,
  output logic              invY,
  output logic              carryIn,
  output logic              logicK,
  output logic              logicL,
  output logic              addSel,
  output logic              absSel,
  output logic              updFlags
);
  import aluPkg::*;

  aluFunc    funcE;
  moveTarget moveRegE;
  dspWord    constD;
  dspWord    oneHot;
  logic      validE;
  logic      absE;
  logic      toAfE;
  logic      moveValidE;
  logic      constNullE;
  logic      constLoad;
  logic      aluAr;
  logic      aluAf;

  always_comb
  begin
    oneHot = dspWord'(1) << {yy, cc};  // Bit position is yy*4+cc
    case (bo)
      boSingle:   constD = oneHot;
      boInverted: constD = ~oneHot;
      default:    constD = '0;
    endcase
  end

  assign constLoad = instValid && (yop == ySelConst) && ({cc, bo} != 4'b0000);

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      validE     <= 1'b0;
      moveValidE <= 1'b0;
      funcE      <= '0;
      absE       <= 1'b0;
      toAfE      <= 1'b0;
      xopE       <= '0;
      yopE       <= '0;
      shadowE    <= 1'b0;
      moveRegE   <= '0;
      moveDataE  <= '0;
      constNullE <= 1'b0;
      constE     <= '0;
    end
    else
    begin
      validE     <= instValid;
      moveValidE <= moveValid;
      funcE      <= func;
      absE       <= absOp;
      toAfE      <= toAf;
      xopE       <= xop;
      yopE       <= yop;
      shadowE    <= shadow;
      moveRegE   <= moveReg;
      moveDataE  <= moveData;
      constNullE <= ({cc, bo} == 4'b0000);  // Constant operand then reads as zero
      if (constLoad)
        constE <= constD;
    end
  end

  assign aluAr = validE && !toAfE;
  assign aluAf = validE && toAfE;

  assign updAX0r = !shadowE && moveValidE && (moveRegE == moveAx0);
  assign updAX0s = shadowE && moveValidE && (moveRegE == moveAx0);
  assign updAX1r = !shadowE && moveValidE && (moveRegE == moveAx1);
  assign updAX1s = shadowE && moveValidE && (moveRegE == moveAx1);
  assign updAY0r = !shadowE && moveValidE && (moveRegE == moveAy0);
  assign updAY0s = shadowE && moveValidE && (moveRegE == moveAy0);
  assign updAY1r = !shadowE && moveValidE && (moveRegE == moveAy1);
  assign updAY1s = shadowE && moveValidE && (moveRegE == moveAy1);
  assign updARr  = !shadowE && (aluAr || (moveValidE && (moveRegE == moveAr)));
  assign updARs  = shadowE && (aluAr || (moveValidE && (moveRegE == moveAr)));
  assign updAFr  = !shadowE && (aluAf || (moveValidE && (moveRegE == moveAf)));
  assign updAFs  = shadowE && (aluAf || (moveValidE && (moveRegE == moveAf)));

  assign resultIsMove = {!aluAf, !aluAr};  // ALU result wins over a move
  assign updFlags     = validE;
  assign absSel       = validE && absE && (funcE == funcPassX);

  always_comb
  begin
    zeroX   = 1'b0;
    invX    = 1'b0;
    zeroY   = 1'b0;
    invY    = 1'b0;
    carryIn = 1'b0;
    case (funcE)
      funcPassY:
        zeroX = 1'b1;
      funcIncY:
      begin
        zeroX   = 1'b1;
        carryIn = 1'b1;
      end
      funcAddC:
        carryIn = acFlag;
      funcAdd:
        carryIn = 1'b0;
      funcNotY:
      begin
        zeroX = 1'b1;
        invY  = 1'b1;
      end
      funcNegY:
      begin
        zeroX   = 1'b1;
        invY    = 1'b1;
        carryIn = 1'b1;
      end
      funcSubC:
      begin
        invY    = 1'b1;
        carryIn = acFlag;
      end
      funcSub:
      begin
        invY    = 1'b1;
        carryIn = 1'b1;
      end
      funcDecY:
      begin
        zeroX = 1'b1;
        invX  = 1'b1;  // Adds all ones to Y
      end
      funcRevSub:
      begin
        invX    = 1'b1;
        carryIn = 1'b1;
      end
      funcRevSubC:
      begin
        invX    = 1'b1;
        carryIn = acFlag;
      end
      funcNotX:
      begin
        invX  = 1'b1;
        zeroY = 1'b1;
      end
      funcPassX:
      begin
        zeroY   = 1'b1;
        invX    = absE && xSign;  // Negative X is negated for ABS
        carryIn = absE && xSign;
      end
      default:
        carryIn = 1'b0;
    endcase
    if ((yopE == ySelConst) && constNullE)
      zeroY = 1'b1;
  end

  always_comb
  begin
    case (funcE)
      funcAnd: {logicK, logicL, addSel} = 3'b000;
      funcOr:  {logicK, logicL, addSel} = 3'b010;
      funcXor: {logicK, logicL, addSel} = 3'b110;
      default: {logicK, logicL, addSel} = 3'b111;
    endcase
  end

  // A move names one of the six ALU registers
  moveTargetLegal: assert property (@(posedge DSPCLK) disable iff (T_RST)
    moveValid |-> (moveReg <= moveAf));

endmodule

// File: rtl/aluPkg.sv
package aluPkg;

  typedef logic [15:0] dspWord;     // Register, operand and result word
  typedef logic [3:0]  aluFunc;     // ALU function code
  typedef logic [2:0]  xSel;        // X operand select
  typedef logic [1:0]  ySel;        // Y operand select
  typedef logic [1:0]  constField;  // The yy, cc and bo fields of the constant
  typedef logic [2:0]  moveTarget;  // Register move destination
  typedef logic [4:0]  statusWord;  // AZ, AN, AV, AC, AS from bit 0 upward

  localparam aluFunc funcPassY   = 4'h0;  // Y
  localparam aluFunc funcIncY    = 4'h1;  // Y+1
  localparam aluFunc funcAddC    = 4'h2;  // X+Y+C
  localparam aluFunc funcAdd     = 4'h3;  // X+Y
  localparam aluFunc funcNotY    = 4'h4;  // NOT Y
  localparam aluFunc funcNegY    = 4'h5;  // -Y
  localparam aluFunc funcSubC    = 4'h6;  // X-Y+C-1
  localparam aluFunc funcSub     = 4'h7;  // X-Y
  localparam aluFunc funcDecY    = 4'h8;  // Y-1
  localparam aluFunc funcRevSub  = 4'h9;  // Y-X
  localparam aluFunc funcRevSubC = 4'hA;  // Y-X+C-1
  localparam aluFunc funcNotX    = 4'hB;  // NOT X
  localparam aluFunc funcAnd     = 4'hC;
  localparam aluFunc funcOr      = 4'hD;
  localparam aluFunc funcXor     = 4'hE;
  localparam aluFunc funcPassX   = 4'hF;  // PASS X or ABS X with the abs qualifier

  localparam xSel xSelAx0 = 3'd0;
  localparam xSel xSelAx1 = 3'd1;
  localparam xSel xSelAr  = 3'd2;  // Highest legal X select

  localparam ySel ySelAy0   = 2'd0;
  localparam ySel ySelAy1   = 2'd1;
  localparam ySel ySelAf    = 2'd2;
  localparam ySel ySelConst = 2'd3;

  localparam constField boSingle   = 2'b01;  // Single set bit
  localparam constField boInverted = 2'b11;  // Single cleared bit

  localparam moveTarget moveAx0 = 3'd0;
  localparam moveTarget moveAx1 = 3'd1;
  localparam moveTarget moveAy0 = 3'd2;
  localparam moveTarget moveAy1 = 3'd3;
  localparam moveTarget moveAr  = 3'd4;
  localparam moveTarget moveAf  = 3'd5;

  localparam int aZBit = 0;
  localparam int aNBit = 1;
  localparam int aVBit = 2;
  localparam int aCBit = 3;
  localparam int aSBit = 4;

endpackage

// File: rtl/aluRegFile.sv
module aluRegFile (
  input  logic           DSPCLK,
  input  logic           T_RST,
  input  logic           updAX0r,
  input  logic           updAX0s,
  input  logic           updAX1r,
  input  logic           updAX1s,
  input  logic           updAY0r,
  input  logic           updAY0s,
  input  logic           updAY1r,
  input  logic           updAY1s,
  input  logic           updARr,
  input  logic           updARs,
  input  logic           updAFr,
  input  logic           updAFs,
  input  aluPkg::dspWord moveDataE,
  input  aluPkg::dspWord aluResult,
  input  logic [1:0]     resultIsMove,
  input  aluPkg::xSel    xopE,
  input  aluPkg::ySel    yopE,
  input  logic           shadowE,
  input  aluPkg::dspWord constE,
  output aluPkg::dspWord xOperand,
  output aluPkg::dspWord yOperand,
  output aluPkg::dspWord ar,
  output aluPkg::dspWord af
);
  import aluPkg::*;

  dspWord ax0Reg [2];  // Index 0 is the primary bank and index 1 the shadow bank
  dspWord ax1Reg [2];
  dspWord ay0Reg [2];
  dspWord ay1Reg [2];
  dspWord arReg  [2];
  dspWord afReg  [2];
  dspWord arNext;
  dspWord afNext;
  logic   aluWrite;

  assign arNext = resultIsMove[0] ? moveDataE : aluResult;
  assign afNext = resultIsMove[1] ? moveDataE : aluResult;

  always_ff @(posedge DSPCLK or posedge T_RST)
  begin
    if (T_RST)
    begin
      ax0Reg <= '{default: '0};
      ax1Reg <= '{default: '0};
      ay0Reg <= '{default: '0};
      ay1Reg <= '{default: '0};
      arReg  <= '{default: '0};
      afReg  <= '{default: '0};
    end
    else
    begin
      if (updAX0r) ax0Reg[0] <= moveDataE;
      if (updAX0s) ax0Reg[1] <= moveDataE;
      if (updAX1r) ax1Reg[0] <= moveDataE;
      if (updAX1s) ax1Reg[1] <= moveDataE;
      if (updAY0r) ay0Reg[0] <= moveDataE;
      if (updAY0s) ay0Reg[1] <= moveDataE;
      if (updAY1r) ay1Reg[0] <= moveDataE;
      if (updAY1s) ay1Reg[1] <= moveDataE;
      if (updARr)  arReg[0]  <= arNext;
      if (updARs)  arReg[1]  <= arNext;
      if (updAFr)  afReg[0]  <= afNext;
      if (updAFs)  afReg[1]  <= afNext;
    end
  end

  always_comb
  begin
    case (xopE)
      xSelAx0: xOperand = ax0Reg[shadowE];
      xSelAx1: xOperand = ax1Reg[shadowE];
      xSelAr:  xOperand = arReg[shadowE];  // Lets back-to-back instructions chain through AR
      default: xOperand = '0;
    endcase
  end

  always_comb
  begin
    case (yopE)
      ySelAy0: yOperand = ay0Reg[shadowE];
      ySelAy1: yOperand = ay1Reg[shadowE];
      ySelAf:  yOperand = afReg[shadowE];
      default: yOperand = constE;
    endcase
  end

  assign ar = arReg[0];
  assign af = afReg[0];

  assign aluWrite = ((updARr || updARs) && !resultIsMove[0]) ||
                    ((updAFr || updAFs) && !resultIsMove[1]);

  // An ALU result must come from a legal X select
  xopInRange: assert property (@(posedge DSPCLK) disable iff (T_RST)
    aluWrite |-> (xopE <= xSelAr));

endmodule

// File: rtl/aluUnit.sv
module aluUnit (
  input  logic              DSPCLK,
  input  logic              T_RST,
  input  logic              instValid,
  input  aluPkg::aluFunc    func,
  input  logic              absOp,
  input  aluPkg::xSel       xop,
  input  aluPkg::ySel       yop,
  input  aluPkg::constField yy,
  input  aluPkg::constField cc,
  input  aluPkg::constField bo,
  input  logic              toAf,
  input  logic              moveValid,
  input  aluPkg::moveTarget moveReg,
  input  aluPkg::dspWord    moveData,
  input  logic              shadow,
  output aluPkg::dspWord    ar,
  output aluPkg::dspWord    af,
  output aluPkg::statusWord astat
);
  import aluPkg::*;

  logic       updAX0r, updAX0s, updAX1r, updAX1s, updAY0r, updAY0s;
  logic       updAY1r, updAY1s, updARr, updARs, updAFr, updAFs;
  logic [1:0] resultIsMove;
  dspWord     moveDataE;
  dspWord     constE;
  dspWord     xOperand;
  dspWord     yOperand;
  dspWord     aluResult;
  xSel        xopE;
  ySel        yopE;
  logic       shadowE;
  logic       zeroX, invX, zeroY, invY, carryIn;
  logic       logicK, logicL, addSel, absSel, updFlags;
  logic       acFlag;
  logic       xSign;

  aluDecoder u_aluDecoder (
    .DSPCLK, .T_RST, .instValid, .func, .absOp, .xop, .yop, .yy, .cc, .bo, .toAf,
    .moveValid, .moveReg, .moveData, .shadow, .acFlag, .xSign,
    .updAX0r, .updAX0s, .updAX1r, .updAX1s, .updAY0r, .updAY0s,
    .updAY1r, .updAY1s, .updARr, .updARs, .updAFr, .updAFs,
    .resultIsMove, .moveDataE, .xopE, .yopE, .shadowE, .constE,
    .zeroX, .invX, .zeroY, .invY, .carryIn, .logicK, .logicL, .addSel, .absSel, .updFlags
  );

  aluRegFile u_aluRegFile (
    .DSPCLK, .T_RST,
    .updAX0r, .updAX0s, .updAX1r, .updAX1s, .updAY0r, .updAY0s,
    .updAY1r, .updAY1s, .updARr, .updARs, .updAFr, .updAFs,
    .moveDataE, .aluResult, .resultIsMove, .xopE, .yopE, .shadowE, .constE,
    .xOperand, .yOperand, .ar, .af
  );

  aluDatapath u_aluDatapath (
    .DSPCLK, .T_RST, .xOperand, .yOperand,
    .zeroX, .invX, .zeroY, .invY, .carryIn, .logicK, .logicL, .addSel, .absSel, .updFlags,
    .aluResult, .astat, .acFlag, .xSign
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f aluUnit.f --top-module aluTb -o aluSim

simOutput=$(./obj_dir/aluSim)
echo "$simOutput"

if echo "$simOutput" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: sim/aluClockGen.sv
module aluClockGen (
  output logic DSPCLK,
  output logic T_RST
);

  initial
  begin
    DSPCLK = 1'b0;
    forever #50 DSPCLK = ~DSPCLK;  // Period of 100
  end

  initial
  begin
    T_RST = 1'b1;
    repeat (2) @(posedge DSPCLK);
    #10 T_RST = 1'b0;  // Released just after the second rising edge
  end

endmodule

// File: sim/aluPatterns.hex
// Columns (hex): test instValid func absOp xop yop yy cc bo toAf moveValid moveReg moveData shadow
// then expected ar, expected af, expected astat; a test number of ffff ends the list
01 0 0 0 0 0 0 0 0 0 0 0 0000 0 0000 0000 00
02 0 0 0 0 0 0 0 0 0 1 0 1234 0 0000 0000 00
03 0 0 0 0 0 0 0 0 0 1 1 8000 0 0000 0000 00
04 0 0 0 0 0 0 0 0 0 1 2 0f0f 0 0000 0000 00
05 0 0 0 0 0 0 0 0 0 1 3 7fff 0 0000 0000 00
06 1 0 0 0 0 0 0 0 0 0 0 0000 0 0f0f 0000 00
07 1 1 0 0 1 0 0 0 0 0 0 0000 0 8000 0000 06
08 1 3 0 0 0 0 0 0 0 0 0 0000 0 2143 0000 00
09 1 7 0 0 0 0 0 0 0 0 0 0000 0 0325 0000 08
0a 1 2 0 0 0 0 0 0 0 0 0 0000 0 2144 0000 00
0b 1 2 0 0 0 0 0 0 0 0 0 0000 0 2143 0000 00
0c 1 6 0 0 0 0 0 0 0 0 0 0000 0 0324 0000 08
0d 1 6 0 0 0 0 0 0 0 0 0 0000 0 0325 0000 08
0e 1 9 0 0 0 0 0 0 0 0 0 0000 0 fcdb 0000 02
0f 1 a 0 0 0 0 0 0 0 0 0 0000 0 fcda 0000 02
10 1 7 0 0 0 0 0 0 0 0 0 0000 0 0325 0000 08
11 1 a 0 0 0 0 0 0 0 0 0 0000 0 fcdb 0000 02
12 1 4 0 0 0 0 0 0 0 0 0 0000 0 f0f0 0000 02
13 1 5 0 0 0 0 0 0 0 0 0 0000 0 f0f1 0000 02
14 1 8 0 0 0 0 0 0 0 0 0 0000 0 0f0e 0000 08
15 1 b 0 0 0 0 0 0 0 0 0 0000 0 edcb 0000 02
16 1 7 0 0 0 0 0 0 0 0 0 0000 0 0325 0000 08
17 1 c 0 0 0 0 0 0 0 0 0 0000 0 0204 0000 00
18 1 d 0 0 0 0 0 0 0 0 0 0000 0 1f3f 0000 00
19 1 e 0 1 0 0 0 0 0 0 0 0000 0 8f0f 0000 02
1a 1 c 0 1 0 0 0 0 0 0 0 0000 0 0000 0000 01
1b 1 f 0 0 0 0 0 0 0 0 0 0000 0 1234 0000 00
1c 1 f 1 1 0 0 0 0 0 0 0 0000 0 8000 0000 16
1d 1 0 0 0 0 0 0 0 0 0 0 0000 0 0f0f 0000 10
1e 1 f 1 0 0 0 0 0 0 0 0 0000 0 1234 0000 00
1f 1 0 0 0 3 2 1 1 0 0 0 0000 0 0200 0000 00
20 1 3 0 0 3 3 3 3 0 0 0 0000 0 9233 0000 06
21 1 3 0 2 0 0 0 0 0 0 0 0000 0 a142 0000 02
22 1 3 0 2 0 0 0 0 0 0 0 0000 0 b051 0000 02
23 0 0 0 0 0 0 0 0 0 1 0 0011 1 b051 0000 02
24 0 0 0 0 0 0 0 0 0 1 2 0022 1 b051 0000 02
25 1 3 0 0 0 0 0 0 0 0 0 0000 1 b051 0000 00
26 0 0 0 0 0 0 0 0 0 1 5 0033 1 b051 0000 00
27 1 7 0 2 2 0 0 0 0 0 0 0000 1 b051 0000 09
28 1 3 0 2 2 0 0 0 1 0 0 0000 0 b051 b051 02
29 1 0 0 0 0 0 0 0 0 1 4 dead 0 0f0f b051 00
2a 0 0 0 0 0 0 0 0 0 1 4 dead 0 dead b051 00
ffff 0 0 0 0 0 0 0 0 0 0 0 0000 0 0000 0000 00

// File: sim/aluTb.sv
module aluTb;
  import aluPkg::*;

  localparam int fieldCount = 17;  // Hex words per vector line
  localparam int maxVectors = 64;

  logic      DSPCLK;
  logic      T_RST;
  logic      instValid;
  aluFunc    func;
  logic      absOp;
  xSel       xop;
  ySel       yop;
  constField yy;
  constField cc;
  constField bo;
  logic      toAf;
  logic      moveValid;
  moveTarget moveReg;
  dspWord    moveData;
  logic      shadow;
  dspWord    ar;
  dspWord    af;
  statusWord astat;

  logic [15:0] patMem [0:fieldCount*maxVectors-1];
  int          vectorCount;
  int          passCount;
  int          failCount;
  int          cycleCount;
  int          cycleLimit;

  aluClockGen u_aluClockGen (
    .DSPCLK,
    .T_RST
  );

  aluUnit u_aluUnit (
    .DSPCLK, .T_RST, .instValid, .func, .absOp, .xop, .yop, .yy, .cc, .bo, .toAf,
    .moveValid, .moveReg, .moveData, .shadow, .ar, .af, .astat
  );

  task automatic idleInputs();
    instValid = 1'b0;
    func      = '0;
    absOp     = 1'b0;
    xop       = '0;
    yop       = '0;
    yy        = '0;
    cc        = '0;
    bo        = '0;
    toAf      = 1'b0;
    moveValid = 1'b0;
    moveReg   = '0;
    moveData  = '0;
    shadow    = 1'b0;
  endtask

  task automatic driveVector(input int idx);
    int base;
    base      = idx * fieldCount;
    instValid = patMem[base+1][0];
    func      = patMem[base+2][3:0];
    absOp     = patMem[base+3][0];
    xop       = patMem[base+4][2:0];
    yop       = patMem[base+5][1:0];
    yy        = patMem[base+6][1:0];
    cc        = patMem[base+7][1:0];
    bo        = patMem[base+8][1:0];
    toAf      = patMem[base+9][0];
    moveValid = patMem[base+10][0];
    moveReg   = patMem[base+11][2:0];
    moveData  = patMem[base+12];
    shadow    = patMem[base+13][0];
  endtask

  task automatic checkResults(input int idx);
    int        base;
    dspWord    expAr;
    dspWord    expAf;
    statusWord expAstat;
    base     = idx * fieldCount;
    expAr    = patMem[base+14];
    expAf    = patMem[base+15];
    expAstat = patMem[base+16][4:0];
    if (ar == expAr && af == expAf && astat == expAstat)
    begin
      passCount++;
      $display("[PASS] test %0d", patMem[base]);
    end
    else
    begin
      failCount++;
      $display("[FAIL] test %0d: expected ar=%h af=%h astat=%h, actual ar=%h af=%h astat=%h",
               patMem[base], expAr, expAf, expAstat, ar, af, astat);
    end
  endtask

  // Watchdog armed once the vector count is known
  always @(posedge DSPCLK)
  begin
    cycleCount = cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
    begin
      $display("Timeout: the run went past %0d clock cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    bit endFound;
    idleInputs();
    passCount   = 0;
    failCount   = 0;
    cycleCount  = 0;
    cycleLimit  = 0;
    endFound    = 1'b0;
    vectorCount = maxVectors;
    $readmemh("sim/aluPatterns.hex", patMem);
    for (int v = 0; v < maxVectors; v++)
    begin
      if (!endFound && patMem[v*fieldCount] == 16'hffff)
      begin
        vectorCount = v;  // The line with test number ffff closes the list
        endFound    = 1'b1;
      end
    end
    if (!endFound)
    begin
      failCount++;
      $display("The pattern file has no end marker line");
    end
    cycleLimit = vectorCount * 2 + 20;

    repeat (2) @(posedge DSPCLK);
    wait (T_RST == 1'b0);

    // A vector's effect is visible two edges after it is driven
    for (int i = 0; i < vectorCount + 2; i++)
    begin
      @(posedge DSPCLK);
      #10;
      if (i >= 2)
        checkResults(i - 2);
      if (i < vectorCount)
        driveVector(i);
      else
        idleInputs();
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", vectorCount, passCount, failCount);
    if (failCount == 0 && vectorCount > 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
